// ==== common/alu_ctrl_pkg.sv ====
/*
 * Control-side definitions for the floating-point ALU.
 * The latency constants must match the register depth of each unit.
 */
`default_nettype none

package alu_ctrl_pkg;

    //////////////////////////////////////////////////
    // operation codes
    //////////////////////////////////////////////////
    // 0xx arithmetic, 1xx special; div and sqrt are reserved
    typedef enum logic [2:0] {
        OP_ADD       = 3'b000,
        OP_SUB       = 3'b001,
        OP_MUL       = 3'b010,
        OP_DIV_RSVD  = 3'b011,
        OP_REDUCE    = 3'b100,
        OP_NOP1      = 3'b101,
        OP_SQRT_RSVD = 3'b110,
        OP_NOP3      = 3'b111
    } alu_op_t;

    //////////////////////////////////////////////////
    // sequencer types and unit depths
    //////////////////////////////////////////////////
    typedef logic [5:0] latency_t;   // cycles from en to done

    typedef enum logic {
        SEQ_IDLE,
        SEQ_BUSY
    } seq_state_t;

    localparam latency_t ADD_LATENCY = 6'd2;   // two register stages
    localparam latency_t MUL_LATENCY = 6'd2;   // two register stages

endpackage : alu_ctrl_pkg

`default_nettype wire

// ==== common/fp_operand_if.sv ====
/*
 * Operand and result bundle between the ALU top and its arithmetic units.
 * Results are pipelined; the top qualifies them with the sequencer.
 */
`timescale 1ns/1ps
`default_nettype none

interface fp_operand_if import fp_types_pkg::*; ();

    fp_word_t a;         // first operand
    fp_word_t b;         // second operand
    logic     sub;       // negate b in the adder
    fp_word_t sum;       // adder result, 2 cycles late
    fp_word_t product;   // multiplier result, 2 cycles late

    modport alu        (output a, b, sub, input sum, product);
    modport adder      (input a, b, sub, output sum);
    modport multiplier (input a, b, output product);

endinterface : fp_operand_if

`default_nettype wire

// ==== common/fp_types_pkg.sv ====
/*
 * IEEE single-precision field widths and word types.
 * Subnormals are not represented and are read as zero by every unit.
 */
`default_nettype none

package fp_types_pkg;

    //////////////////////////////////////////////////
    // word and field types
    //////////////////////////////////////////////////
    typedef logic [31:0] fp_word_t;   // sign, exponent, fraction
    typedef logic [7:0]  fp_exp_t;    // biased exponent field
    typedef logic [23:0] fp_mant_t;   // fraction with the hidden one

    //////////////////////////////////////////////////
    // exponent constants
    //////////////////////////////////////////////////
    localparam int      FP_BIAS    = 127;
    localparam int      FP_EXP_MAX = 254;     // largest finite exponent
    localparam fp_exp_t FP_EXP_INF = 8'hFF;   // infinity / NaN exponent

endpackage : fp_types_pkg

`default_nettype wire

// ==== fp_alu.f ====
common/fp_types_pkg.sv
common/alu_ctrl_pkg.sv
common/fp_operand_if.sv
fp_alu/fp_add_unit.sv
fp_alu/fp_mul_unit.sv
fp_alu/latency_sequencer.sv
fp_alu/fp_alu.sv
verif/fp_alu_checker.sv
verif/tb_fp_alu.sv

// ==== fp_alu/fp_add_unit.sv ====
/*
 * Two-stage add/subtract, truncating toward zero with no guard bits.
 * Zero-exponent inputs are flushed; inf/NaN inputs are not handled.
 * Overflow gives signed infinity, underflow and cancellation give +0.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_unit import fp_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    fp_operand_if.adder ops
);

    // position of the leading one counted from bit 23
    function automatic logic [4:0] lead_zeros(input logic [23:0] v);
        logic [4:0] n;
        n = 5'd0;
        for (int i = 0; i < 24; i++) begin
            if (v[i])
                n = 5'(23 - i);   // highest set bit wins
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // stage 1: order, flush and align
    //////////////////////////////////////////////////
    logic        a_zero, b_zero;
    logic        b_sign;
    logic [30:0] a_mag, b_mag;
    fp_exp_t     big_exp, small_exp, exp_diff;
    fp_mant_t    big_mant, small_mant;
    logic        big_sign, small_sign;

    fp_mant_t    s1_big, s1_small;
    fp_exp_t     s1_exp;
    logic        s1_sign, s1_sub;

    always_comb begin
        a_zero = (ops.a[30:23] == '0);
        b_zero = (ops.b[30:23] == '0);
        b_sign = ops.b[31] ^ ops.sub;          // subtract is add of -b
        a_mag  = a_zero ? '0 : ops.a[30:0];
        b_mag  = b_zero ? '0 : ops.b[30:0];

        if (b_mag > a_mag) begin
            big_exp    = b_mag[30:23];
            big_mant   = {~b_zero, b_mag[22:0]};
            big_sign   = b_sign;
            small_exp  = a_mag[30:23];
            small_mant = {~a_zero, a_mag[22:0]};
            small_sign = ops.a[31];
        end else begin
            big_exp    = a_mag[30:23];
            big_mant   = {~a_zero, a_mag[22:0]};
            big_sign   = ops.a[31];
            small_exp  = b_mag[30:23];
            small_mant = {~b_zero, b_mag[22:0]};
            small_sign = b_sign;
        end

        exp_diff = big_exp - small_exp;        // never negative after ordering
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_big   <= '0;
            s1_small <= '0;
            s1_exp   <= '0;
            s1_sign  <= 1'b0;
            s1_sub   <= 1'b0;
        end else begin
            s1_big   <= big_mant;
            s1_small <= small_mant >> exp_diff;   // shifted-out bits dropped
            s1_exp   <= big_exp;
            s1_sign  <= big_sign;
            s1_sub   <= big_sign ^ small_sign;
        end
    end

    //////////////////////////////////////////////////
    // stage 2: add, normalize, range check
    //////////////////////////////////////////////////
    logic [24:0]       raw;
    logic [4:0]        lz;
    fp_mant_t          norm_mant;
    logic signed [9:0] norm_exp;
    fp_word_t          sum_d, sum_q;

    always_comb begin
        if (s1_sub)
            raw = {1'b0, s1_big} - {1'b0, s1_small};   // big >= small, no borrow
        else
            raw = {1'b0, s1_big} + {1'b0, s1_small};

        lz = lead_zeros(raw[23:0]);

        if (raw[24]) begin
            norm_mant = raw[24:1];                     // carry, low bit lost
            norm_exp  = $signed({2'b00, s1_exp}) + 10'sd1;
        end else begin
            norm_mant = raw[23:0] << lz;
            norm_exp  = $signed({2'b00, s1_exp}) - $signed({5'b00000, lz});
        end

        if (raw == '0)
            sum_d = '0;                                // exact cancellation is +0
        else if (norm_exp > FP_EXP_MAX)
            sum_d = {s1_sign, FP_EXP_INF, 23'd0};
        else if (norm_exp < 10'sd1)
            sum_d = '0;
        else
            sum_d = {s1_sign, norm_exp[7:0], norm_mant[22:0]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sum_q <= '0;
        else
            sum_q <= sum_d;
    end

    assign ops.sum = sum_q;

endmodule : fp_add_unit

`default_nettype wire

// ==== fp_alu/fp_alu.sv ====
/*
 * Single-precision ALU: add, sub, reduce (as add) and mul, 2-cycle latency.
 * Operands and operation must stay stable from en until done.
 * Div and sqrt codes, and the no-op codes, pass op1 through with done high.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_alu
    import fp_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  fp_word_t   op1,
    input  fp_word_t   op2,
    input  logic [2:0] operation,
    output fp_word_t   out,
    output logic [1:0] flag,
    output logic       done
);

    fp_operand_if ops_if ();

    alu_op_t  op_code;
    logic     use_add, use_mul;
    logic     seq_start, seq_finish;
    latency_t seq_latency;

    //////////////////////////////////////////////////
    // operand distribution
    //////////////////////////////////////////////////
    assign op_code    = alu_op_t'(operation);
    assign ops_if.a   = op1;
    assign ops_if.b   = op2;
    assign ops_if.sub = (op_code == OP_SUB);

    fp_add_unit u_add (
        .clk   (clk),
        .rst_n (rst_n),
        .ops   (ops_if.adder)
    );

    fp_mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .ops   (ops_if.multiplier)
    );

    latency_sequencer u_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (seq_start),
        .latency (seq_latency),
        .finish  (seq_finish)
    );

    //////////////////////////////////////////////////
    // decode and result select
    //////////////////////////////////////////////////
    always_comb begin
        use_add = 1'b0;
        use_mul = 1'b0;
        case (op_code)
            OP_ADD, OP_SUB, OP_REDUCE: use_add = 1'b1;   // reduce runs on the adder
            OP_MUL:                    use_mul = 1'b1;
            default: ;                                   // pass-through codes
        endcase
    end

    always_comb begin
        seq_start   = 1'b0;
        seq_latency = ADD_LATENCY;
        out         = op1;
        done        = 1'b1;           // pass-through is always ready
        if (use_add) begin
            seq_start   = en;
            seq_latency = ADD_LATENCY;
            out         = ops_if.sum;
            done        = seq_finish;
        end else if (use_mul) begin
            seq_start   = en;
            seq_latency = MUL_LATENCY;
            out         = ops_if.product;
            done        = seq_finish;
        end
    end

    assign flag[1] = |out;     // nonzero
    assign flag[0] = out[31];  // sign

endmodule : fp_alu

`default_nettype wire

// ==== fp_alu/fp_mul_unit.sv ====
/*
 * Two-stage multiply, truncating the 48-bit product toward zero.
 * Zero-exponent inputs are flushed; inf/NaN inputs are not handled.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unit import fp_types_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    fp_operand_if.multiplier ops
);

    //////////////////////////////////////////////////
    // stage 1: mantissa product and exponent sum
    //////////////////////////////////////////////////
    fp_exp_t  a_exp, b_exp;
    fp_mant_t a_mant, b_mant;

    logic [47:0]       s1_prod;
    logic signed [9:0] s1_exp;   // unbiased sum, may go negative
    logic              s1_sign;
    logic              s1_zero;

    assign a_exp  = ops.a[30:23];
    assign b_exp  = ops.b[30:23];
    assign a_mant = {1'b1, ops.a[22:0]};
    assign b_mant = {1'b1, ops.b[22:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_prod <= '0;
            s1_exp  <= '0;
            s1_sign <= 1'b0;
            s1_zero <= 1'b1;
        end else begin
            s1_prod <= a_mant * b_mant;
            s1_exp  <= $signed({2'b00, a_exp}) + $signed({2'b00, b_exp}) - 10'(FP_BIAS);
            s1_sign <= ops.a[31] ^ ops.b[31];
            s1_zero <= (a_exp == '0) || (b_exp == '0);   // flushed operand
        end
    end

    //////////////////////////////////////////////////
    // stage 2: one-bit normalize and range check
    //////////////////////////////////////////////////
    logic [22:0]       frac;
    logic signed [9:0] norm_exp;
    fp_word_t          prod_d, prod_q;

    always_comb begin
        if (s1_prod[47]) begin
            frac     = s1_prod[46:24];   // product in [2,4)
            norm_exp = s1_exp + 10'sd1;
        end else begin
            frac     = s1_prod[45:23];
            norm_exp = s1_exp;
        end

        if (s1_zero)
            prod_d = '0;
        else if (norm_exp > FP_EXP_MAX)
            prod_d = {s1_sign, FP_EXP_INF, 23'd0};
        else if (norm_exp < 10'sd1)
            prod_d = '0;
        else
            prod_d = {s1_sign, norm_exp[7:0], frac};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            prod_q <= '0;
        else
            prod_q <= prod_d;
    end

    assign ops.product = prod_q;

endmodule : fp_mul_unit

`default_nettype wire

// ==== fp_alu/latency_sequencer.sv ====
/*
 * Counts a fixed number of cycles after start and pulses finish.
 * Start is ignored while busy. A latency of 0 wraps the count and
 * finishes after 64 busy cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module latency_sequencer import alu_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  latency_t latency,
    output logic     finish
);

    seq_state_t state, state_next;
    latency_t   count, count_next;
    latency_t   max_count;            // latency captured at start

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            count     <= '0;
            max_count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
            if (start && (state == SEQ_IDLE))
                max_count <= latency;
        end
    end

    always_comb begin
        state_next = state;
        count_next = count;
        finish     = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    state_next = SEQ_BUSY;
                    count_next = 6'd1;   // cycle after start is count 1
                end
            end
            SEQ_BUSY: begin
                count_next = count + 6'd1;
                if (count == max_count) begin
                    finish     = 1'b1;
                    count_next = '0;
                    state_next = SEQ_IDLE;
                end
            end
            default: state_next = SEQ_IDLE;
        endcase
    end

endmodule : latency_sequencer

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f fp_alu.f --top-module tb_fp_alu -o sim_fp_alu \
    && ./obj_dir/sim_fp_alu | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== verif/fp_alu_checker.sv ====
/*
 * Watches the ALU ports on the falling edge and compares them against a model.
 * Assumes the caller holds operands and operation stable until done.
 * Infinity and NaN operands are not modeled.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_alu_checker
    import fp_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  fp_word_t   op1,
    input  fp_word_t   op2,
    input  logic [2:0] operation,
    input  fp_word_t   out,
    input  logic [1:0] flag,
    input  logic       done,
    output int         check_count,
    output int         error_count
);

    localparam longint HIDDEN = 64'd8388608;   // 2^23, the implied one

    int       checks = 0;
    int       errors = 0;
    logic     busy = 1'b0;
    int       age = 0;
    latency_t lat = ADD_LATENCY;
    fp_word_t exp_out = '0;
    logic     counting;
    logic     exp_done;
    logic     flag_due;
    fp_word_t flag_word;   // model result that the flags describe

    assign check_count = checks;
    assign error_count = errors;

    //////////////////////////////////////////////////
    // reference arithmetic
    //////////////////////////////////////////////////
    function automatic fp_word_t model_add(input fp_word_t a, input fp_word_t b,
                                           input logic neg_b);
        int     ea, eb, e_big, e_small, e;
        longint ma, mb, m_big, m_small, r;
        logic   sa, sb, s_big, s_small;
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        sa = a[31];
        sb = b[31] ^ neg_b;
        ma = (ea == 0) ? 64'd0 : longint'(a[22:0]) + HIDDEN;   // flush subnormals
        mb = (eb == 0) ? 64'd0 : longint'(b[22:0]) + HIDDEN;
        if ((eb > ea) || ((eb == ea) && (mb > ma))) begin
            e_big   = eb;
            m_big   = mb;
            s_big   = sb;
            e_small = ea;
            m_small = ma;
            s_small = sa;
        end else begin
            e_big   = ea;
            m_big   = ma;
            s_big   = sa;
            e_small = eb;
            m_small = mb;
            s_small = sb;
        end
        if (e_big - e_small > 40)
            m_small = 0;
        else
            m_small = m_small >> (e_big - e_small);         // alignment truncates
        if (s_big != s_small)
            r = m_big - m_small;
        else
            r = m_big + m_small;
        if (r == 0)
            return '0;
        e = e_big;
        if (r >= 2 * HIDDEN) begin
            r = r >> 1;
            e = e + 1;
        end
        while (r < HIDDEN) begin
            r = r << 1;
            e = e - 1;
        end
        if (e > FP_EXP_MAX)
            return {s_big, FP_EXP_INF, 23'd0};
        if (e < 1)
            return '0;
        return {s_big, 8'(e), r[22:0]};
    endfunction

    function automatic fp_word_t model_mul(input fp_word_t a, input fp_word_t b);
        int          ea, eb, e;
        longint      p;
        logic [22:0] frac;
        logic        s;
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        s  = a[31] ^ b[31];
        if ((ea == 0) || (eb == 0))
            return '0;
        p = (longint'(a[22:0]) + HIDDEN) * (longint'(b[22:0]) + HIDDEN);
        e = ea + eb - FP_BIAS;
        if (p[47]) begin
            frac = p[46:24];   // product in [2,4)
            e    = e + 1;
        end else begin
            frac = p[45:23];
        end
        if (e > FP_EXP_MAX)
            return {s, FP_EXP_INF, 23'd0};
        if (e < 1)
            return '0;
        return {s, 8'(e), frac};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks = checks + 1;
        if (got !== expected) begin
            errors = errors + 1;
            $display("ERR %s: got %h expected %h (op %b, time %0t)",
                     name, got, expected, operation, $time);
        end
    endtask

    //////////////////////////////////////////////////
    // cycle model, sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        counting = (operation == OP_ADD) || (operation == OP_SUB) ||
                   (operation == OP_MUL) || (operation == OP_REDUCE);
        flag_due = 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
            age  = 0;
            if (counting)
                check_value("done", 32'(done), 32'd0);
        end else if (!counting) begin
            check_value("done", 32'(done), 32'd1);   // pass-through codes
            check_value("out", out, op1);
            flag_due  = 1'b1;
            flag_word = op1;
        end else begin
            exp_done = 1'b0;
            if (busy) begin
                age = age + 1;
                if (age == int'(lat)) begin
                    exp_done  = 1'b1;
                    busy      = 1'b0;
                    check_value("out", out, exp_out);
                    flag_due  = 1'b1;
                    flag_word = exp_out;
                end
            end else if (en) begin
                busy = 1'b1;                         // this is cycle 0
                age  = 0;
                lat  = (operation == OP_MUL) ? MUL_LATENCY : ADD_LATENCY;
                if (operation == OP_MUL)
                    exp_out = model_mul(op1, op2);
                else
                    exp_out = model_add(op1, op2, operation == OP_SUB);
            end
            check_value("done", 32'(done), 32'(exp_done));
        end
        if (flag_due)
            check_value("flag", 32'(flag), 32'({flag_word != '0, flag_word[31]}));
    end

endmodule : fp_alu_checker

`default_nettype wire

// ==== verif/tb_fp_alu.sv ====
/*
 * Seeded random testbench for the floating-point ALU.
 * Operands never use exponent 255; inputs change 2 ns after the rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_alu
    import fp_types_pkg::*;
    import alu_ctrl_pkg::*;
();

    logic       clk = 1'b0;
    logic       rst_n;
    logic       en;
    fp_word_t   op1, op2;
    logic [2:0] operation;
    fp_word_t   out;
    logic [1:0] flag;
    logic       done;

    int seed = 38;
    int timeouts = 0;
    int check_count, error_count;

    always #20 clk = ~clk;   // 40 ns period

    fp_alu UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .op1       (op1),
        .op2       (op2),
        .operation (operation),
        .out       (out),
        .flag      (flag),
        .done      (done)
    );

    fp_alu_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .op1         (op1),
        .op2         (op2),
        .operation   (operation),
        .out         (out),
        .flag        (flag),
        .done        (done),
        .check_count (check_count),
        .error_count (error_count)
    );

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic make_operands(input alu_op_t op, output fp_word_t a, output fp_word_t b);
        int   mode, ea, eb;
        logic cancel;
        a      = $random(seed);
        b      = $random(seed);
        cancel = 1'b0;
        mode   = int'({$random(seed)} % 10);
        ea     = 1 + int'({$random(seed)} % 254);
        eb     = 1 + int'({$random(seed)} % 254);
        case (mode)
            6: begin
                if (a[0])
                    ea = 0;                          // flushed operand
                else
                    eb = 0;
            end
            7: begin
                eb = ea + int'({$random(seed)} % 3) - 1;
                if (eb < 1)
                    eb = 1;
                if (eb > 254)
                    eb = 254;
                cancel = b[0];
            end
            8: begin
                ea = 200 + int'({$random(seed)} % 55);   // overflow region
                eb = 200 + int'({$random(seed)} % 55);
            end
            9: begin
                ea = 1 + int'({$random(seed)} % 60);     // underflow region
                eb = 1 + int'({$random(seed)} % 60);
            end
            default: ;
        endcase
        a[30:23] = 8'(ea);
        b[30:23] = 8'(eb);
        if (cancel)
            b = {a[31] ^ (op != OP_SUB), a[30:0]};   // exact cancellation
    endtask

    task automatic run_op(input alu_op_t op);
        fp_word_t a, b;
        logic     extra;
        logic     got;
        int       waited;
        make_operands(op, a, b);
        extra = 1'({$random(seed)} % 2);
        @(posedge clk);
        #2;
        op1       = a;
        op2       = b;
        operation = op;
        en        = 1'b1;
        @(posedge clk);
        #2;
        en = extra;                                  // lands while busy
        @(posedge clk);
        #2;
        en     = 1'b0;
        got    = 1'b0;
        waited = 0;
        while (!got && (waited < 20)) begin
            @(negedge clk);
            if (done === 1'b1)
                got = 1'b1;
            waited = waited + 1;
        end
        if (!got) begin
            timeouts = timeouts + 1;
            $display("done never arrived for operation %s", op.name());
        end
        repeat ({$random(seed)} % 4) @(posedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        en        = 1'b0;
        op1       = '0;
        op2       = '0;
        operation = OP_ADD;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);                   // idle after reset
        for (int i = 0; i < 400; i++)
            run_op(alu_op_t'(3'({$random(seed)} % 8)));
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
        if ((error_count == 0) && (timeouts == 0) && (check_count > 0))
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_fp_alu

`default_nettype wire
